// File: eth_pkg.sv
// stream beat types for the receive path; NUM_PORTS must be at least 2 for PORT_W to be nonzero
package eth_pkg;

    // number of receive ports merged onto the output stream
    localparam int NUM_PORTS = 2;

    // width of the source tag on the merged stream
    localparam int PORT_W = $clog2(NUM_PORTS);

    // one byte-wide stream beat
    typedef struct packed {
        logic [7:0] data;
        logic       last;
        // frame error flag, meaningful on the last beat only
        logic       user;
    } axis_byte_t;

    // merged beat tagged with the port it came from
    typedef struct packed {
        axis_byte_t        beat;
        logic [PORT_W-1:0] source;
    } axis_tagged_t;

endpackage

// File: crc_pkg.sv
// ethernet CRC-32 helpers; bytes enter LSB first and the result is not inverted here
package crc_pkg;

    // normal form of the ethernet polynomial
    localparam logic [31:0] CRC_POLY = 32'h04C11DB7;

    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

    // FCS length in bytes, also the depth of the checker delay line
    localparam int FCS_BYTES = 4;

    // one byte of the reflected galois step
    function automatic logic [31:0] crc32_byte(input logic [31:0] state, input logic [7:0] data);
        logic [31:0] poly_r;
        logic [31:0] c;
        // reflected polynomial, bit i takes bit 31-i
        for (int i = 0; i < 32; i++) begin
            poly_r[i] = CRC_POLY[31-i];
        end
        c = state ^ {24'd0, data};
        for (int b = 0; b < 8; b++) begin
            if (c[0]) begin
                c = (c >> 1) ^ poly_r;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

// File: axis_skid_buffer.sv
// in_valid means a push: the producer may only push while its registered copy of in_ready_early is high
module axis_skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready_early,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t out_data_reg;
    payload_t tmp_data_reg;
    logic     out_valid_reg;
    logic     out_valid_next;
    logic     tmp_valid_reg;
    logic     tmp_valid_next;
    logic     store_in_to_out;
    logic     store_in_to_tmp;
    logic     store_tmp_to_out;

    assign out_data  = out_data_reg;
    assign out_valid = out_valid_reg;

    // ready next cycle unless the temp register could fill this cycle
    assign in_ready_early = out_ready || (!tmp_valid_reg && (!out_valid_reg || !in_valid));

    always_comb begin
        out_valid_next   = out_valid_reg;
        tmp_valid_next   = tmp_valid_reg;
        store_in_to_out  = 1'b0;
        store_in_to_tmp  = 1'b0;
        store_tmp_to_out = 1'b0;

        if (in_valid) begin
            if (out_ready || !out_valid_reg) begin
                out_valid_next  = 1'b1;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                tmp_valid_next  = 1'b1;
                store_in_to_tmp = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next   = tmp_valid_reg;
            tmp_valid_next   = 1'b0;
            store_tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_reg <= 1'b0;
            tmp_valid_reg <= 1'b0;
        end else begin
            out_valid_reg <= out_valid_next;
            tmp_valid_reg <= tmp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_data_reg <= in_data;
        end else if (store_tmp_to_out) begin
            out_data_reg <= tmp_data_reg;
        end
        if (store_in_to_tmp) begin
            tmp_data_reg <= in_data;
        end
    end

    // a stalled beat must not change or vanish
    a_out_data_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_data));
    a_out_valid_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid);

endmodule

// File: eth_fcs_check.sv
// byte-wide FCS strip and check; frames of FCS_BYTES or fewer bytes are dropped without an error strobe
module eth_fcs_check (
    input  logic               clk,
    input  logic               rst,
    input  eth_pkg::axis_byte_t in_beat,
    input  logic               in_valid,
    output logic               in_ready,
    output eth_pkg::axis_byte_t out_beat,
    output logic               out_valid,
    input  logic               out_ready,
    output logic               busy,
    output logic               error_bad_fcs
);

    typedef enum logic {
        ST_IDLE,
        ST_PAYLOAD
    } state_t;

    state_t state_reg;
    state_t state_next;

    // index 0 holds the newest byte
    logic [7:0] dl_data [crc_pkg::FCS_BYTES];
    logic [crc_pkg::FCS_BYTES-1:0] dl_valid;

    logic [31:0] crc_reg;
    logic [31:0] crc_next;
    logic [31:0] rx_fcs;
    logic        fcs_bad;

    logic in_ready_reg;
    logic accept;
    logic push;
    logic ready_early;
    logic busy_reg;
    logic error_reg;
    logic error_next;

    eth_pkg::axis_byte_t int_beat;

    assign in_ready      = in_ready_reg;
    assign busy          = busy_reg;
    assign error_bad_fcs = error_reg;

    always_comb begin
        accept   = in_valid && in_ready_reg;
        crc_next = crc_pkg::crc32_byte(crc_reg, dl_data[crc_pkg::FCS_BYTES-1]);
        // FCS arrives low byte first, so the oldest stored byte is bits 7:0
        rx_fcs   = {in_beat.data, dl_data[0], dl_data[1], dl_data[2]};
        fcs_bad  = rx_fcs != ~crc_next;

        // a byte leaves once FCS_BYTES newer bytes are behind it
        push = accept && dl_valid[crc_pkg::FCS_BYTES-1];

        int_beat.data = dl_data[crc_pkg::FCS_BYTES-1];
        int_beat.last = in_beat.last;
        int_beat.user = in_beat.last && (in_beat.user || fcs_bad);

        error_next = push && in_beat.last && fcs_bad;

        state_next = state_reg;
        case (state_reg)
            ST_IDLE: begin
                if (push && !in_beat.last) begin
                    state_next = ST_PAYLOAD;
                end
            end
            ST_PAYLOAD: begin
                if (accept && in_beat.last) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg    <= ST_IDLE;
            in_ready_reg <= 1'b0;
            busy_reg     <= 1'b0;
            error_reg    <= 1'b0;
            dl_valid     <= '0;
            crc_reg      <= crc_pkg::CRC_INIT;
        end else begin
            state_reg    <= state_next;
            in_ready_reg <= ready_early;
            busy_reg     <= state_next != ST_IDLE;
            error_reg    <= error_next;

            if (accept && in_beat.last) begin
                // frame done or too short, start over
                dl_valid <= '0;
                crc_reg  <= crc_pkg::CRC_INIT;
            end else if (accept) begin
                dl_valid <= {dl_valid[crc_pkg::FCS_BYTES-2:0], 1'b1};
                if (push) begin
                    crc_reg <= crc_next;
                end
            end
        end
    end

    // delay line payload
    always_ff @(posedge clk) begin
        if (accept) begin
            dl_data[0] <= in_beat.data;
            for (int i = 1; i < crc_pkg::FCS_BYTES; i++) begin
                dl_data[i] <= dl_data[i-1];
            end
        end
    end

    axis_skid_buffer #(
        .payload_t(eth_pkg::axis_byte_t)
    ) u_out_buf (
        .clk           (clk),
        .rst           (rst),
        .in_data       (int_beat),
        .in_valid      (push),
        .in_ready_early(ready_early),
        .out_data      (out_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready)
    );

endmodule

// File: axis_frame_arbiter.sv
// frame-locked round robin; a port is released only after its last beat leaves the output
module axis_frame_arbiter (
    input  logic                                         clk,
    input  logic                                         rst,
    input  eth_pkg::axis_byte_t [eth_pkg::NUM_PORTS-1:0] in_beat,
    input  logic [eth_pkg::NUM_PORTS-1:0]                in_valid,
    output logic [eth_pkg::NUM_PORTS-1:0]                in_ready,
    output eth_pkg::axis_tagged_t                        out_beat,
    output logic                                         out_valid,
    input  logic                                         out_ready
);

    logic locked;
    // set once the granted frame's last beat is taken in
    logic tail_in;
    // current grant, and the last winner once unlocked
    logic [eth_pkg::PORT_W-1:0] grant;
    logic [eth_pkg::PORT_W-1:0] sel;
    logic ready_reg;
    logic ready_early;
    logic push;
    logic out_last_hs;

    eth_pkg::axis_tagged_t tag_beat;

    always_comb begin
        int  idx;
        logic found;
        sel   = grant;
        found = 1'b0;
        // search starts just after the last winner
        for (int k = 1; k <= eth_pkg::NUM_PORTS; k++) begin
            idx = (int'(grant) + k) % eth_pkg::NUM_PORTS;
            if (!found && in_valid[idx]) begin
                sel   = idx[eth_pkg::PORT_W-1:0];
                found = 1'b1;
            end
        end

        in_ready = '0;
        if (locked && !tail_in && ready_reg) begin
            in_ready[grant] = 1'b1;
        end
        push = in_valid[grant] && in_ready[grant];

        tag_beat.beat   = in_beat[grant];
        tag_beat.source = grant;

        out_last_hs = out_valid && out_ready && out_beat.beat.last;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            locked    <= 1'b0;
            tail_in   <= 1'b0;
            grant     <= '0;
            ready_reg <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            if (!locked) begin
                if (|in_valid) begin
                    locked <= 1'b1;
                    grant  <= sel;
                end
            end else begin
                if (push && in_beat[grant].last) begin
                    tail_in <= 1'b1;
                end
                if (out_last_hs) begin
                    locked  <= 1'b0;
                    tail_in <= 1'b0;
                end
            end
        end
    end

    axis_skid_buffer #(
        .payload_t(eth_pkg::axis_tagged_t)
    ) u_out_buf (
        .clk           (clk),
        .rst           (rst),
        .in_data       (tag_beat),
        .in_valid      (push),
        .in_ready_early(ready_early),
        .out_data      (out_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready)
    );

    // beats on the output belong to the port that still holds the lock
    a_grant_held: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> locked && out_beat.source == grant);
    // a frame on the output never switches source before its last beat
    a_frame_source: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_beat.beat.last |=> !out_valid || $stable(out_beat.source));

endmodule

// File: eth_fcs_rx_top.sv
// multi-port FCS receive front end; output beats carry their source port, and frames never interleave
module eth_fcs_rx_top (
    input  logic                                         clk,
    input  logic                                         rst,
    input  eth_pkg::axis_byte_t [eth_pkg::NUM_PORTS-1:0] in_beat,
    input  logic [eth_pkg::NUM_PORTS-1:0]                in_valid,
    output logic [eth_pkg::NUM_PORTS-1:0]                in_ready,
    output eth_pkg::axis_tagged_t                        out_beat,
    output logic                                         out_valid,
    input  logic                                         out_ready,
    output logic [eth_pkg::NUM_PORTS-1:0]                busy,
    output logic [eth_pkg::NUM_PORTS-1:0]                error_bad_fcs
);

    // checker to arbiter streams
    eth_pkg::axis_byte_t [eth_pkg::NUM_PORTS-1:0] chk_beat;
    logic [eth_pkg::NUM_PORTS-1:0]                chk_valid;
    logic [eth_pkg::NUM_PORTS-1:0]                chk_ready;

    for (genvar i = 0; i < eth_pkg::NUM_PORTS; i++) begin : u_fcs_check
        eth_fcs_check u_chk (
            .clk          (clk),
            .rst          (rst),
            .in_beat      (in_beat[i]),
            .in_valid     (in_valid[i]),
            .in_ready     (in_ready[i]),
            .out_beat     (chk_beat[i]),
            .out_valid    (chk_valid[i]),
            .out_ready    (chk_ready[i]),
            .busy         (busy[i]),
            .error_bad_fcs(error_bad_fcs[i])
        );
    end

    axis_frame_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (chk_beat),
        .in_valid (chk_valid),
        .in_ready (chk_ready),
        .out_beat (out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

// File: tb_eth_fcs_rx.sv
// random-frame testbench for the two-port FCS path; the round-robin check peeks at u_dut.chk_valid
module tb_eth_fcs_rx;

    localparam int NUM_FRAMES     = 30;
    localparam int MAX_PAYLOAD    = 40;
    localparam int TOTAL_FRAMES   = NUM_FRAMES * eth_pkg::NUM_PORTS;
    localparam int MAX_FRAME      = MAX_PAYLOAD + crc_pkg::FCS_BYTES;
    localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * MAX_FRAME * 4 + 1000;

    localparam int T_RESET  = 0;
    localparam int T_STRIP  = 1;
    localparam int T_FLAG   = 2;
    localparam int T_STROBE = 3;
    localparam int T_ARB    = 4;
    localparam int T_IDLE   = 5;
    localparam int N_TESTS  = 6;

    logic                                         clk;
    logic                                         rst;
    eth_pkg::axis_byte_t [eth_pkg::NUM_PORTS-1:0] in_beat;
    logic [eth_pkg::NUM_PORTS-1:0]                in_valid;
    logic [eth_pkg::NUM_PORTS-1:0]                in_ready;
    eth_pkg::axis_tagged_t                        out_beat;
    logic                                         out_valid;
    logic                                         out_ready;
    logic [eth_pkg::NUM_PORTS-1:0]                busy;
    logic [eth_pkg::NUM_PORTS-1:0]                error_bad_fcs;

    int seed;
    int cycles;
    int frames_seen;
    int total_errors;
    int errors [N_TESTS];
    bit timed_out;

    // per-port stimulus and expectations
    eth_pkg::axis_byte_t stim_q     [eth_pkg::NUM_PORTS][$];
    logic [7:0]          exp_data_q [eth_pkg::NUM_PORTS][$];
    int                  exp_len_q  [eth_pkg::NUM_PORTS][$];
    logic                exp_user_q [eth_pkg::NUM_PORTS][$];
    int                  corrupt_cnt [eth_pkg::NUM_PORTS];
    int                  strobe_cnt  [eth_pkg::NUM_PORTS];
    bit                  sent        [eth_pkg::NUM_PORTS];

    // output frame tracking
    bit   in_frame;
    int   cur_src;
    int   remain;
    logic cur_user;
    bit   have_prev;
    int   prev_src;
    bit   decide_pending;
    bit   other_wait;

    eth_fcs_rx_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .in_beat      (in_beat),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_beat     (out_beat),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .busy         (busy),
        .error_bad_fcs(error_bad_fcs)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic string test_label(input int t);
        case (t)
            T_RESET:  return "reset";
            T_STRIP:  return "fcs_strip";
            T_FLAG:   return "error_flag";
            T_STROBE: return "strobe_count";
            T_ARB:    return "arbitration";
            default:  return "idle";
        endcase
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // bitwise reflected CRC-32, one data bit per step
    function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ data[i];
            c  = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ 32'hEDB8_8320;
            end
        end
        return c;
    endfunction

    task automatic report_fail(input int t, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        errors[t]++;
        $display("Fail %s: %s expected %0h actual %0h", test_label(t), what, exp, act);
    endtask

    task automatic report_error(input int t, input string msg);
        errors[t]++;
        $display("error in %s: %s", test_label(t), msg);
    endtask

    task automatic build_frames();
        int                  len;
        bit                  corrupt;
        bit                  tuser;
        logic [31:0]         crc;
        logic [31:0]         fcs;
        eth_pkg::axis_byte_t b;
        for (int p = 0; p < eth_pkg::NUM_PORTS; p++) begin
            for (int f = 0; f < NUM_FRAMES; f++) begin
                len     = 1 + rand_below(MAX_PAYLOAD);
                corrupt = rand_below(4) == 0;
                tuser   = rand_below(8) == 0;
                crc     = 32'hFFFF_FFFF;
                for (int i = 0; i < len; i++) begin
                    b.data = 8'(rand_below(256));
                    b.last = 1'b0;
                    b.user = 1'b0;
                    crc    = crc_update(crc, b.data);
                    stim_q[p].push_back(b);
                    exp_data_q[p].push_back(b.data);
                end
                fcs = ~crc;
                if (corrupt) begin
                    fcs = fcs ^ (32'd1 << rand_below(32));
                end
                // FCS goes out low byte first
                for (int i = 0; i < 4; i++) begin
                    b.data = fcs[8*i +: 8];
                    b.last = i == 3;
                    b.user = i == 3 && tuser;
                    stim_q[p].push_back(b);
                end
                exp_len_q[p].push_back(len);
                exp_user_q[p].push_back(tuser || corrupt);
                if (corrupt) begin
                    corrupt_cnt[p]++;
                end
            end
        end
    endtask

    // called on the falling edge; in_ready is stable until the next rising edge
    task automatic drive_inputs();
        for (int p = 0; p < eth_pkg::NUM_PORTS; p++) begin
            if (sent[p]) begin
                void'(stim_q[p].pop_front());
            end
            if (sent[p] || !in_valid[p]) begin
                if (stim_q[p].size() > 0 && rand_below(4) != 0) begin
                    in_valid[p] = 1'b1;
                    in_beat[p]  = stim_q[p][0];
                end else begin
                    in_valid[p] = 1'b0;
                end
            end
            sent[p] = in_valid[p] && in_ready[p];
        end
        out_ready = rand_below(3) != 0;
    endtask

    // records the beat that moves on the coming rising edge
    task automatic watch_output();
        eth_pkg::axis_tagged_t ob;
        int                    s;
        logic [7:0]            exp_data;
        ob = out_beat;
        s  = int'(ob.source);
        if (out_valid && out_ready) begin
            if (!in_frame && exp_len_q[s].size() == 0) begin
                report_error(T_ARB, $sformatf("beat from port %0d with no frame expected", s));
            end else begin
                if (!in_frame) begin
                    // the other port was waiting, so round robin had to pick it
                    if (have_prev && other_wait && s == prev_src) begin
                        report_fail(T_ARB, "frame source", 32'(1 - prev_src), 32'(s));
                    end
                    in_frame = 1'b1;
                    cur_src  = s;
                    remain   = exp_len_q[s].pop_front();
                    cur_user = exp_user_q[s].pop_front();
                end else if (s != cur_src) begin
                    report_fail(T_ARB, "source inside a frame", 32'(cur_src), 32'(s));
                end
                if (remain == 0) begin
                    report_error(T_STRIP, "beat past the end of the expected frame");
                end else begin
                    exp_data = exp_data_q[cur_src].pop_front();
                    if (ob.beat.data !== exp_data) begin
                        report_fail(T_STRIP, $sformatf("data port %0d", cur_src),
                                    32'(exp_data), 32'(ob.beat.data));
                    end
                    if (ob.beat.last !== (remain == 1)) begin
                        report_fail(T_STRIP, $sformatf("last port %0d", cur_src),
                                    32'(remain == 1), 32'(ob.beat.last));
                    end
                    if (ob.beat.user !== (remain == 1 && cur_user)) begin
                        report_fail(T_FLAG, $sformatf("user port %0d", cur_src),
                                    32'(remain == 1 && cur_user), 32'(ob.beat.user));
                    end
                    remain--;
                end
                if (ob.beat.last) begin
                    // drop what an early last left behind
                    while (remain > 0) begin
                        void'(exp_data_q[cur_src].pop_front());
                        remain--;
                    end
                    in_frame       = 1'b0;
                    have_prev      = 1'b1;
                    prev_src       = cur_src;
                    decide_pending = 1'b1;
                    frames_seen++;
                end
            end
        end
    endtask

    initial begin
        seed           = 32'h5734;
        rst            = 1'b1;
        in_beat        = '0;
        in_valid       = '0;
        out_ready      = 1'b0;
        cycles         = 0;
        frames_seen    = 0;
        timed_out      = 1'b0;
        in_frame       = 1'b0;
        remain         = 0;
        have_prev      = 1'b0;
        prev_src       = 0;
        decide_pending = 1'b0;
        other_wait     = 1'b0;
        for (int t = 0; t < N_TESTS; t++) begin
            errors[t] = 0;
        end
        for (int p = 0; p < eth_pkg::NUM_PORTS; p++) begin
            corrupt_cnt[p] = 0;
            strobe_cnt[p]  = 0;
            sent[p]        = 1'b0;
        end
        build_frames();

        repeat (16) @(negedge clk);
        if (out_valid !== 1'b0 || in_ready !== '0 || busy !== '0 || error_bad_fcs !== '0) begin
            report_error(T_RESET, "outputs not quiet during reset");
        end
        rst = 1'b0;

        while (frames_seen < TOTAL_FRAMES && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                timed_out = 1'b1;
            end
            for (int p = 0; p < eth_pkg::NUM_PORTS; p++) begin
                if (error_bad_fcs[p]) begin
                    strobe_cnt[p]++;
                end
            end
            // first cycle with a request after release is the grant decision
            if (decide_pending && |u_dut.chk_valid) begin
                other_wait     = u_dut.chk_valid[1 - prev_src];
                decide_pending = 1'b0;
            end
            drive_inputs();
            watch_output();
        end

        if (timed_out) begin
            $display("timeout: only %0d of %0d frames came out in %0d cycles",
                     frames_seen, TOTAL_FRAMES, cycles);
        end else begin
            @(negedge clk);
            in_valid  = '0;
            out_ready = 1'b1;
            repeat (4) @(negedge clk);
            for (int p = 0; p < eth_pkg::NUM_PORTS; p++) begin
                if (strobe_cnt[p] != corrupt_cnt[p]) begin
                    report_fail(T_STROBE, $sformatf("pulses port %0d", p),
                                32'(corrupt_cnt[p]), 32'(strobe_cnt[p]));
                end
                if (exp_len_q[p].size() != 0 || exp_data_q[p].size() != 0) begin
                    report_error(T_IDLE, $sformatf("frames still expected on port %0d", p));
                end
            end
            if (busy !== '0) begin
                report_fail(T_IDLE, "busy", 32'd0, 32'(busy));
            end
            if (out_valid !== 1'b0) begin
                report_fail(T_IDLE, "out_valid", 32'd0, 32'(out_valid));
            end
        end

        total_errors = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            total_errors += errors[t];
            if (errors[t] == 0) begin
                $display("%-12s passed", test_label(t));
            end else begin
                $display("%-12s failed with %0d errors", test_label(t), errors[t]);
            end
        end
        $display("frames %0d of %0d, cycles %0d, errors %0d",
                 frames_seen, TOTAL_FRAMES, cycles, total_errors);
        if (timed_out || total_errors != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

// File: filelist.f
eth_pkg.sv
crc_pkg.sv
axis_skid_buffer.sv
eth_fcs_check.sv
axis_frame_arbiter.sv
eth_fcs_rx_top.sv
tb_eth_fcs_rx.sv

// File: Makefile
# Verilator build and run for the FCS receive front end

VERILATOR ?= verilator
TOP       ?= tb_eth_fcs_rx
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
